// ==== bus_pkg.sv ====
package bus_pkg;

    // sram-like fetch and memory ports
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // size codes carried on mem_size
    // 0 byte, 1 halfword, 2 word
    localparam logic [1:0] size_word = 2'd2; // 4-byte access, the only one issued

    // config port of the register block
    localparam int cfg_addr_width = 2; // four word registers, three in use

endpackage

// ==== cache_pkg.sv ====
package cache_pkg;

    // geometry: two ways, one word per line
    localparam int index_width  = 10;
    localparam int offset_width = 2;                               // byte offset in a word
    localparam int tag_width    = 32 - index_width - offset_width; // 20 bits
    localparam int num_sets     = 1 << index_width;                // 1024
    localparam int num_ways     = 2;

    // register map of the control block, word addresses on cfg_addr
    localparam logic [1:0] reg_ctrl     = 2'd0; // enable and flush
    localparam logic [1:0] reg_hit_cnt  = 2'd1; // write clears
    localparam logic [1:0] reg_miss_cnt = 2'd2; // write clears

    // bits of the control register
    localparam int ctrl_enable_bit = 0;
    localparam int ctrl_flush_bit  = 1; // strobe, always reads 0

    // event counters
    localparam int cnt_width = 32;

endpackage

// ==== i_cache.sv ====
`timescale 1ns/1ps

module i_cache (
    input  logic                                clk,
    input  logic                                rst,
    // core fetch port
    input  logic                                cpu_inst_req,
    input  logic [bus_pkg::addr_width-1:0]      cpu_inst_addr,
    output logic [bus_pkg::data_width-1:0]      cpu_inst_rdata,
    output logic                                cpu_inst_addr_ok,
    output logic                                cpu_inst_data_ok,
    // memory port
    output logic                                mem_req,
    output logic [bus_pkg::addr_width-1:0]      mem_addr,
    output logic [1:0]                          mem_size,
    input  logic [bus_pkg::data_width-1:0]      mem_rdata,
    input  logic                                mem_addr_ok,
    input  logic                                mem_data_ok,
    // from the register block
    input  logic                                cache_en,
    input  logic                                flush,
    // store lookup, both ways
    input  logic [cache_pkg::num_ways-1:0]                          way_valid,
    input  logic [cache_pkg::num_ways-1:0][cache_pkg::tag_width-1:0] way_tag,
    input  logic [cache_pkg::num_ways-1:0][bus_pkg::data_width-1:0]  way_data,
    input  logic [cache_pkg::num_ways-1:0]                          way_ru,
    // store update
    output logic [cache_pkg::index_width-1:0]   lookup_index,
    output logic                                fill_we,
    output logic                                fill_way,
    output logic [cache_pkg::tag_width-1:0]     fill_tag,
    output logic [bus_pkg::data_width-1:0]      fill_data,
    output logic                                ru_we,
    output logic                                ru_way,
    // event pulses to the counters
    output logic                                hit_evt,
    output logic                                miss_evt
);

    typedef enum logic {
        st_idle,
        st_read  // waiting on memory
    } state_t;

    state_t state;

    logic [cache_pkg::tag_width-1:0]   req_tag;
    logic [cache_pkg::index_width-1:0] req_index;
    logic [cache_pkg::tag_width-1:0]   tag_save;
    logic [cache_pkg::index_width-1:0] index_save;
    logic                              way_save;  // victim picked at the miss
    logic                              addr_rcv;  // memory took the address

    logic [cache_pkg::num_ways-1:0] way_hit;
    logic hit;
    logic hit_way;
    logic victim_way;
    logic accept_hit;
    logic accept_miss;
    logic read_done;

    // address split
    assign req_tag   = cpu_inst_addr[bus_pkg::addr_width-1 -: cache_pkg::tag_width];
    assign req_index = cpu_inst_addr[cache_pkg::offset_width +: cache_pkg::index_width];

    // lookup follows the core in idle, the saved miss otherwise
    assign lookup_index = (state == st_idle) ? req_index : index_save;

    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
        end
    end

    assign hit     = cache_en && !flush && (|way_hit);
    assign hit_way = way_hit[1];

    // an empty way first, else the one not recently used
    always_comb begin
        if (!way_valid[0]) begin
            victim_way = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = way_ru[0]; // way 0 used last -> evict way 1
        end
    end

    assign accept_hit  = (state == st_idle) && cpu_inst_req && hit;
    assign accept_miss = (state == st_idle) && cpu_inst_req && !hit && !flush;
    assign read_done   = (state == st_read) && addr_rcv && mem_data_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept_miss) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (read_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_rcv <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            addr_rcv <= 1'b1;
        end else if (read_done) begin
            addr_rcv <= 1'b0;
        end
    end

    // miss context, held while the memory read runs
    always_ff @(posedge clk) begin
        if (accept_miss) begin
            tag_save   <= req_tag;
            index_save <= req_index;
            way_save   <= victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_evt  <= 1'b0;
            miss_evt <= 1'b0;
        end else begin
            hit_evt  <= accept_hit;
            miss_evt <= accept_miss && cache_en; // bypassed fetches are not counted
        end
    end

    // core side
    assign cpu_inst_rdata   = accept_hit ? way_data[hit_way] : mem_rdata;
    assign cpu_inst_addr_ok = accept_hit || (mem_req && mem_addr_ok);
    assign cpu_inst_data_ok = accept_hit || read_done;

    // memory side
    assign mem_req  = (state == st_read) && !addr_rcv;
    assign mem_addr = {tag_save, index_save, {cache_pkg::offset_width{1'b0}}};
    assign mem_size = bus_pkg::size_word;

    // fill at the closing edge of the read, skipped when disabled or flushing
    assign fill_we   = read_done && cache_en && !flush;
    assign fill_way  = way_save;
    assign fill_tag  = tag_save;
    assign fill_data = mem_rdata;

    assign ru_we  = accept_hit || fill_we;
    assign ru_way = accept_hit ? hit_way : way_save;

endmodule

// ==== icache_store.sv ====
`timescale 1ns/1ps

module icache_store (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic [cache_pkg::index_width-1:0]   lookup_index,
    // line fill
    input  logic                                fill_we,
    input  logic                                fill_way,
    input  logic [cache_pkg::tag_width-1:0]     fill_tag,
    input  logic [bus_pkg::data_width-1:0]      fill_data,
    // recently-used update
    input  logic                                ru_we,
    input  logic                                ru_way,
    // lookup result
    output logic [cache_pkg::num_ways-1:0]                          way_valid,
    output logic [cache_pkg::num_ways-1:0][cache_pkg::tag_width-1:0] way_tag,
    output logic [cache_pkg::num_ways-1:0][bus_pkg::data_width-1:0]  way_data,
    output logic [cache_pkg::num_ways-1:0]                          way_ru
);

    // valid bits as flops, one vector per way
    logic [cache_pkg::num_sets-1:0] valid_q [cache_pkg::num_ways];

    // tag and word arrays
    logic [cache_pkg::tag_width-1:0] tag_mem  [cache_pkg::num_ways][cache_pkg::num_sets];
    logic [bus_pkg::data_width-1:0]  data_mem [cache_pkg::num_ways][cache_pkg::num_sets];

    // one bit per set: the way used last
    logic ru_mem [cache_pkg::num_sets];
    logic ru_bit;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                valid_q[w] <= '0; // whole cache invalid in one cycle
            end
        end else if (fill_we) begin
            valid_q[fill_way][lookup_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[fill_way][lookup_index]  <= fill_tag;
            data_mem[fill_way][lookup_index] <= fill_data;
        end
    end

    always_ff @(posedge clk) begin
        if (ru_we) begin
            ru_mem[lookup_index] <= ru_way;
        end
    end

    assign ru_bit = ru_mem[lookup_index];

    // asynchronous read so a hit answers in the request cycle
    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            way_valid[w] = valid_q[w][lookup_index];
            way_tag[w]   = tag_mem[w][lookup_index];
            way_data[w]  = data_mem[w][lookup_index];
        end
    end

    // marked way reads as used, the other as not
    assign way_ru[0] = ~ru_bit;
    assign way_ru[1] = ru_bit;

endmodule

// ==== icache_ctrl_regs.sv ====
`timescale 1ns/1ps

module icache_ctrl_regs (
    input  logic                                clk,
    input  logic                                rst,
    // config port
    input  logic                                cfg_wr,
    input  logic [bus_pkg::cfg_addr_width-1:0]  cfg_addr,
    input  logic [bus_pkg::data_width-1:0]      cfg_wdata,
    output logic [bus_pkg::data_width-1:0]      cfg_rdata,
    // cache events
    input  logic                                hit_evt,
    input  logic                                miss_evt,
    // controls
    output logic                                cache_en,
    output logic                                flush
);

    logic [cache_pkg::cnt_width-1:0] hit_cnt;
    logic [cache_pkg::cnt_width-1:0] miss_cnt;

    logic wr_ctrl;
    logic wr_hit;
    logic wr_miss;

    assign wr_ctrl = cfg_wr && (cfg_addr == cache_pkg::reg_ctrl);
    assign wr_hit  = cfg_wr && (cfg_addr == cache_pkg::reg_hit_cnt);
    assign wr_miss = cfg_wr && (cfg_addr == cache_pkg::reg_miss_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_en <= 1'b0;
            flush    <= 1'b0;
        end else begin
            flush <= wr_ctrl && cfg_wdata[cache_pkg::ctrl_flush_bit]; // one-cycle strobe
            if (wr_ctrl) begin
                cache_en <= cfg_wdata[cache_pkg::ctrl_enable_bit];
            end
        end
    end

    // counters, a write of any value clears
    always_ff @(posedge clk) begin
        if (rst || wr_hit) begin
            hit_cnt <= '0;
        end else if (hit_evt) begin
            hit_cnt <= hit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || wr_miss) begin
            miss_cnt <= '0;
        end else if (miss_evt) begin
            miss_cnt <= miss_cnt + 1'b1;
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            cache_pkg::reg_ctrl:     cfg_rdata[cache_pkg::ctrl_enable_bit] = cache_en;
            cache_pkg::reg_hit_cnt:  cfg_rdata = bus_pkg::data_width'(hit_cnt);
            cache_pkg::reg_miss_cnt: cfg_rdata = bus_pkg::data_width'(miss_cnt);
            default:                 cfg_rdata = '0; // unmapped
        endcase
    end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                                clk,
    input  logic                                rst,
    // core fetch port
    input  logic                                cpu_inst_req,
    input  logic [bus_pkg::addr_width-1:0]      cpu_inst_addr,
    output logic [bus_pkg::data_width-1:0]      cpu_inst_rdata,
    output logic                                cpu_inst_addr_ok,
    output logic                                cpu_inst_data_ok,
    // memory port
    output logic                                mem_req,
    output logic [bus_pkg::addr_width-1:0]      mem_addr,
    output logic [1:0]                          mem_size,
    input  logic [bus_pkg::data_width-1:0]      mem_rdata,
    input  logic                                mem_addr_ok,
    input  logic                                mem_data_ok,
    // config port
    input  logic                                cfg_wr,
    input  logic [bus_pkg::cfg_addr_width-1:0]  cfg_addr,
    input  logic [bus_pkg::data_width-1:0]      cfg_wdata,
    output logic [bus_pkg::data_width-1:0]      cfg_rdata
);

    logic cache_en;
    logic flush;
    logic hit_evt;
    logic miss_evt;

    logic [cache_pkg::index_width-1:0] lookup_index;
    logic                              fill_we;
    logic                              fill_way;
    logic [cache_pkg::tag_width-1:0]   fill_tag;
    logic [bus_pkg::data_width-1:0]    fill_data;
    logic                              ru_we;
    logic                              ru_way;

    logic [cache_pkg::num_ways-1:0]                          way_valid;
    logic [cache_pkg::num_ways-1:0][cache_pkg::tag_width-1:0] way_tag;
    logic [cache_pkg::num_ways-1:0][bus_pkg::data_width-1:0]  way_data;
    logic [cache_pkg::num_ways-1:0]                          way_ru;

    i_cache i_i_cache (
        .clk, .rst,
        .cpu_inst_req, .cpu_inst_addr, .cpu_inst_rdata, .cpu_inst_addr_ok, .cpu_inst_data_ok,
        .mem_req, .mem_addr, .mem_size, .mem_rdata, .mem_addr_ok, .mem_data_ok,
        .cache_en, .flush,
        .way_valid, .way_tag, .way_data, .way_ru,
        .lookup_index, .fill_we, .fill_way, .fill_tag, .fill_data, .ru_we, .ru_way,
        .hit_evt, .miss_evt
    );

    icache_store i_icache_store (
        .clk, .rst, .flush, .lookup_index,
        .fill_we, .fill_way, .fill_tag, .fill_data, .ru_we, .ru_way,
        .way_valid, .way_tag, .way_data, .way_ru
    );

    icache_ctrl_regs i_icache_ctrl_regs (
        .clk, .rst,
        .cfg_wr, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .hit_evt, .miss_evt,
        .cache_en, .flush
    );

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mem_req,
    input  logic [bus_pkg::addr_width-1:0]  mem_addr,
    output logic [bus_pkg::data_width-1:0]  mem_rdata,
    output logic                            mem_addr_ok,
    output logic                            mem_data_ok
);

    logic [bus_pkg::addr_width-1:0] addr_held;
    int unsigned wait_cycles;

    // contents follow the word address
    function automatic logic [bus_pkg::data_width-1:0] word_at(
        input logic [bus_pkg::addr_width-1:0] addr
    );
        return {2'b00, addr[bus_pkg::addr_width-1:2]} ^ 32'h5a5a0000;
    endfunction

    // one read at a time with outputs changed on the falling edge
    initial begin
        void'($urandom(32'h3992)); // seeds the run
        addr_held   = '0;
        mem_rdata   = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                wait_cycles = 1 + ($urandom % 4); // 1 to 4 cycles to take the address
                repeat (wait_cycles - 1) @(negedge clk);
                mem_addr_ok = 1'b1;
                addr_held   = mem_addr;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                // data no earlier than the cycle after addr_ok
                wait_cycles = 1 + ($urandom % 4);
                repeat (wait_cycles - 1) @(negedge clk);
                mem_rdata   = word_at(addr_held);
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

// ==== tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;

    localparam int max_tests = 64;

    logic                                clk;
    logic                                rst;
    logic                                cpu_inst_req;
    logic [bus_pkg::addr_width-1:0]      cpu_inst_addr;
    logic [bus_pkg::data_width-1:0]      cpu_inst_rdata;
    logic                                cpu_inst_addr_ok;
    logic                                cpu_inst_data_ok;
    logic                                mem_req;
    logic [bus_pkg::addr_width-1:0]      mem_addr;
    logic [1:0]                          mem_size;
    logic [bus_pkg::data_width-1:0]      mem_rdata;
    logic                                mem_addr_ok;
    logic                                mem_data_ok;
    logic                                cfg_wr;
    logic [bus_pkg::cfg_addr_width-1:0]  cfg_addr;
    logic [bus_pkg::data_width-1:0]      cfg_wdata;
    logic [bus_pkg::data_width-1:0]      cfg_rdata;

    logic [31:0] test_words [0:4*max_tests-1]; // op, addr, value, hit per test
    int          num_tests;
    int          idx;
    int          errors;
    int          errs_before;
    int          tests_failed;
    int          cycle_cnt;
    int          timeout_limit;
    string       test_name;

    icache_top i_icache_top (
        .clk, .rst,
        .cpu_inst_req, .cpu_inst_addr, .cpu_inst_rdata, .cpu_inst_addr_ok, .cpu_inst_data_ok,
        .mem_req, .mem_addr, .mem_size, .mem_rdata, .mem_addr_ok, .mem_data_ok,
        .cfg_wr, .cfg_addr, .cfg_wdata, .cfg_rdata
    );

    tb_mem_model i_mem_model (
        .clk, .rst, .mem_req, .mem_addr, .mem_rdata, .mem_addr_ok, .mem_data_ok
    );

    always #10 clk = ~clk;

    // run limit counted from the end of reset
    always @(posedge clk) begin
        if (!rst) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt >= timeout_limit) begin
                $display("timeout: the DUT gave no response within %0d cycles", cycle_cnt);
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    // request held until addr_ok
    // a hit shows data_ok in the request cycle
    task automatic run_fetch(input logic [31:0] addr, input logic [31:0] exp_data,
                             input logic exp_hit);
        int          cycles;
        logic        done;
        logic        addr_taken;
        logic        addr_seen;
        logic        got_hit;
        logic [31:0] got_data;
        cycles    = 0;
        done      = 1'b0;
        addr_seen = 1'b0;
        got_hit   = 1'b0;
        got_data  = '0;
        @(negedge clk);
        cpu_inst_req  = 1'b1;
        cpu_inst_addr = addr;
        while (!done) begin
            #5; // mid low phase
            addr_taken = cpu_inst_addr_ok;
            if (cpu_inst_addr_ok) begin
                addr_seen = 1'b1;
            end
            if (mem_req) begin
                assert (mem_size === 2'd2) else begin // word access
                    $display("FAILED %s mem_size: expected %0d, actual %0d",
                             test_name, 2'd2, mem_size);
                    errors++;
                end
            end
            if (cpu_inst_data_ok) begin
                done     = 1'b1;
                got_data = cpu_inst_rdata;
                got_hit  = (cycles == 0);
            end
            @(negedge clk);
            if (addr_taken) begin
                cpu_inst_req = 1'b0;
            end
            cycles++;
        end
        cpu_inst_req = 1'b0;
        assert (addr_seen) else begin
            $display("%s: the cache returned data_ok without ever raising addr_ok", test_name);
            errors++;
        end
        assert (got_data === exp_data) else begin
            $display("FAILED %s data: expected %h, actual %h", test_name, exp_data, got_data);
            errors++;
        end
        assert (got_hit === exp_hit) else begin
            $display("FAILED %s hit: expected %0d, actual %0d", test_name, exp_hit, got_hit);
            errors++;
        end
    endtask

    task automatic write_cfg(input logic [31:0] addr, input logic [31:0] value);
        @(negedge clk);
        cfg_wr    = 1'b1;
        cfg_addr  = addr[bus_pkg::cfg_addr_width-1:0];
        cfg_wdata = value;
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    task automatic read_cfg(input logic [31:0] addr, input logic [31:0] exp_value);
        logic [bus_pkg::data_width-1:0] got;
        @(negedge clk);
        cfg_addr = addr[bus_pkg::cfg_addr_width-1:0];
        #5;
        got = cfg_rdata;
        assert (got === exp_value) else begin
            $display("FAILED %s: expected %h, actual %h", test_name, exp_value, got);
            errors++;
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        cpu_inst_req  = 1'b0;
        cpu_inst_addr = '0;
        cfg_wr        = 1'b0;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        errors        = 0;
        tests_failed  = 0;
        cycle_cnt     = 0;
        for (idx = 0; idx < 4 * max_tests; idx++) begin
            test_words[idx] = 32'hf; // end marker where the file stops
        end
        $readmemh("icache_testdata.txt", test_words);
        num_tests = 0;
        while (num_tests < max_tests && test_words[4*num_tests] != 32'hf) begin
            num_tests++;
        end
        timeout_limit = num_tests * 12;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (idx = 0; idx < num_tests; idx++) begin
            errs_before = errors;
            case (test_words[4*idx])
                32'h1: begin
                    test_name = $sformatf("fetch %h", test_words[4*idx+1]);
                    run_fetch(test_words[4*idx+1], test_words[4*idx+2], test_words[4*idx+3][0]);
                end
                32'h2: begin
                    test_name = $sformatf("config write reg %0d", test_words[4*idx+1]);
                    write_cfg(test_words[4*idx+1], test_words[4*idx+2]);
                end
                32'h3: begin
                    test_name = $sformatf("config read reg %0d", test_words[4*idx+1]);
                    read_cfg(test_words[4*idx+1], test_words[4*idx+2]);
                end
                default: begin
                    test_name = "unknown";
                    $display("test %0d has an unknown operation code in the test data", idx + 1);
                    errors++;
                end
            endcase
            if (errors != errs_before) begin
                tests_failed++;
            end
            $display("test %0d %s: %s", idx + 1, test_name,
                     (errors == errs_before) ? "ok" : "mismatch");
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 num_tests, num_tests - tests_failed, tests_failed);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== icache_testdata.txt ====
// op addr value hit. op 1 fetch with expected word and hit flag, op 2 config write,
// op 3 config read with expected value, op f ends the list
1 00000100 5a5a0040 0  // cache disabled, straight to memory
1 00000100 5a5a0040 0  // no fill while disabled
3 00000001 00000000 0  // hit count
3 00000002 00000000 0  // miss count
2 00000000 00000001 0  // enable
3 00000000 00000001 0
1 00000100 5a5a0040 0
1 00000100 5a5a0040 1
1 00000040 5a5a0010 0  // set 0x10, way 0
1 00001040 5a5a0410 0  // set 0x10, way 1
1 00000040 5a5a0010 1
1 00001040 5a5a0410 1
1 00000040 5a5a0010 1  // 0x1040 now least recent
1 00002040 5a5a0810 0  // evicts 0x1040
1 00000040 5a5a0010 1  // kept
1 00001040 5a5a0410 0  // evicted, evicts 0x2040
1 00000040 5a5a0010 1
3 00000001 00000006 0
3 00000002 00000005 0
2 00000000 00000003 0  // flush, stays enabled
1 00000040 5a5a0010 0
1 00000100 5a5a0040 0
1 00000100 5a5a0040 1
2 00000001 00000000 0  // clear hit count
3 00000001 00000000 0
3 00000002 00000007 0
2 00000002 00000000 0  // clear miss count
3 00000002 00000000 0
2 00000000 00000000 0  // disable
1 00000040 5a5a0010 0  // valid line, but no hit when disabled
3 00000002 00000000 0  // bypass not counted
f 00000000 00000000 0

// ==== build.f ====
bus_pkg.sv
cache_pkg.sv
i_cache.sv
icache_store.sv
icache_ctrl_regs.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the icache testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f build.f -o sim_icache
./obj_dir/sim_icache > sim.log
cat sim.log
if grep -q "Result: FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
